// File: design/core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core package: instruction format, opcodes, register types.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package core_pkg;

   // Register file geometry.
   localparam int REG_AW   = 4;
   localparam int NUM_REGS = 16;

   // Instruction word layout, from the top down: opcode, rd, rs1, rs2.
   localparam int INSTR_W = 15;
   localparam int OPC_LSB = 12;
   localparam int RD_LSB  = 8;
   localparam int RS1_LSB = 4;
   localparam int RS2_LSB = 0;

   // The li immediate overlays the rs1 and rs2 fields.
   localparam int IMM_W = 8;

   typedef logic [REG_AW-1:0]  reg_addr_t;
   typedef logic [IMM_W-1:0]   imm_t;
   typedef logic [INSTR_W-1:0] instr_t;

   typedef enum logic [2:0]
   {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_XOR = 3'd2,
      OP_MUL = 3'd3,
      OP_LI  = 3'd4
   } op_e;

endpackage

`default_nettype wire

// File: design/op_issue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage: ID register, field decode and register reads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module op_issue import core_pkg::*;
(
   input  wire             clk,
   input  wire             rst,
   // Instruction stream.
   input  wire             in_valid,
   input  wire instr_t     in_instr,
   output logic            in_ready,
   // Pipeline control.
   input  wire             advance,
   input  wire             raw_dep_late,
   // Register read request.
   output reg_addr_t       raddr1,
   output reg_addr_t       raddr2,
   output logic            re,
   // Decoded instruction for the RO stage.
   output op_e             iss_op,
   output reg_addr_t       iss_rd,
   output imm_t            iss_imm
);

   logic      id_vld;
   instr_t    id_instr;
   logic      id_take;
   op_e       id_op;
   reg_addr_t id_rs1;
   reg_addr_t id_rs2;

   // ID leaves only through a read, and a late dependence holds it back.
   assign re = id_vld && advance && !raw_dep_late;

   // A new instruction fits when ID is empty or is leaving this cycle.
   assign in_ready = !id_vld || re;
   assign id_take  = in_valid && in_ready;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         id_vld <= 1'b0;
      end
      else if (id_take)
      begin
         id_vld <= 1'b1;
      end
      else if (re)
      begin
         id_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (id_take)
      begin
         id_instr <= in_instr;
      end
   end

   assign id_op  = op_e'(id_instr[OPC_LSB +: $bits(op_e)]);
   assign id_rs1 = id_instr[RS1_LSB +: REG_AW];
   assign id_rs2 = id_instr[RS2_LSB +: REG_AW];

   // For li the source fields hold the immediate. Reading register 0 instead
   // keeps those bits from matching a pending multiply and stalling for nothing.
   assign raddr1 = (id_op == OP_LI) ? '0 : id_rs1;
   assign raddr2 = (id_op == OP_LI) ? '0 : id_rs2;

   assign iss_op  = id_op;
   assign iss_rd  = id_instr[RD_LSB +: REG_AW];
   assign iss_imm = id_instr[RS2_LSB +: IMM_W];

   // A held-back instruction is not read and stays unchanged in ID.
   a_late_hold: assert property (@(posedge clk) disable iff (rst)
      (id_vld && raw_dep_late) |-> !re ##1 (id_vld && $stable(id_instr)));

endmodule

`default_nettype wire

// File: design/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file: two registered read ports, one write port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module reg_file import core_pkg::*;
#(
   parameter int DW = 16
)
(
   input  wire              clk,
   input  wire              rst,
   input  wire reg_addr_t   raddr1,
   input  wire reg_addr_t   raddr2,
   input  wire              re,
   output logic [2*DW-1:0]  rf_din,
   input  wire              we,
   input  wire reg_addr_t   waddr,
   input  wire [DW-1:0]     wdata
);

   logic [DW-1:0] regs [NUM_REGS];

   // Register 0 is cleared by reset and never written, so it reads zero.
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (we && (waddr != '0))
      begin
         regs[waddr] <= wdata;
      end
   end

   // Reads see the array before this edge's write; the bypass covers that case.
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rf_din <= {regs[raddr2], regs[raddr1]};
      end
   end

   a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
      we |-> (waddr != '0));

endmodule

`default_nettype wire

// File: design/operand_bypass.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand bypass: forwards pending stage writes to the reads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module operand_bypass import core_pkg::*;
#(
   parameter int DW = 16
)
(
   input  wire              clk,
   input  wire reg_addr_t   raddr1,
   input  wire reg_addr_t   raddr2,
   input  wire              re,
   input  wire              s1_we,
   input  wire reg_addr_t   s1_waddr,
   input  wire [DW-1:0]     s1_data,
   input  wire              s1_late,
   input  wire              s2_we,
   input  wire reg_addr_t   s2_waddr,
   input  wire [DW-1:0]     s2_data,
   input  wire              s2_late,
   input  wire              s3_we,
   input  wire reg_addr_t   s3_waddr,
   input  wire [DW-1:0]     s3_data,
   input  wire [2*DW-1:0]   rf_din,
   output logic [DW-1:0]    opnd1,
   output logic [DW-1:0]    opnd2,
   output logic             raw_dep_late
);

   reg_addr_t     raddr [2];
   logic [1:0]    hit_s1;
   logic [1:0]    hit_s2;
   logic [1:0]    hit_s3;
   logic [1:0]    dep_late;
   logic [1:0]    hit_s1_q;
   logic [1:0]    hit_s2_q;
   logic [1:0]    hit_s3_q;
   logic [1:0]    late_q;
   logic [DW-1:0] s1_data_q;
   logic [DW-1:0] s2_data_q;
   logic [DW-1:0] s3_data_q;
   logic [DW-1:0] opnd [2];

   assign raddr[0] = raddr1;
   assign raddr[1] = raddr2;

   // Channel 0 is operand 1, channel 1 is operand 2.
   for (genvar c = 0; c < 2; c++)
   begin : g_chan
      assign hit_s1[c] = s1_we && (raddr[c] == s1_waddr);
      assign hit_s2[c] = s2_we && (raddr[c] == s2_waddr);
      assign hit_s3[c] = s3_we && (raddr[c] == s3_waddr);

      // Multiply data does not exist before s3.
      assign dep_late[c] = (hit_s1[c] && s1_late) || (hit_s2[c] && s2_late);

      // s1 holds the youngest write and wins.
      assign opnd[c] = hit_s1_q[c] ? s1_data_q :
                       hit_s2_q[c] ? s2_data_q :
                       hit_s3_q[c] ? s3_data_q :
                                     rf_din[c*DW +: DW];
   end

   assign raw_dep_late = |dep_late;

   always_ff @(posedge clk)
   begin
      if (re)
      begin
         hit_s1_q  <= hit_s1;
         hit_s2_q  <= hit_s2;
         hit_s3_q  <= hit_s3;
         late_q    <= {s2_late, s1_late};
         s1_data_q <= s1_data;
         s2_data_q <= s2_data;
         s3_data_q <= s3_data;
      end
   end

   assign opnd1 = opnd[0];
   assign opnd2 = opnd[1];

   // A captured s1 or s2 hit must never point at a multiply still in flight.
   a_no_late_select: assert property (@(posedge clk)
      re |=> !((|hit_s1_q) && late_q[0]) && !((|hit_s2_q) && late_q[1]));

endmodule

`default_nettype wire

// File: design/exec_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute pipeline: RO, s1, s2 and s3 with the result port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module exec_pipe import core_pkg::*;
#(
   parameter int DW = 16
)
(
   input  wire              clk,
   input  wire              rst,
   input  wire              re,
   input  wire op_e         iss_op,
   input  wire reg_addr_t   iss_rd,
   input  wire imm_t        iss_imm,
   input  wire [DW-1:0]     opnd1,
   input  wire [DW-1:0]     opnd2,
   output logic             advance,
   output logic             s1_we,
   output reg_addr_t        s1_waddr,
   output logic [DW-1:0]    s1_data,
   output logic             s1_late,
   output logic             s2_we,
   output reg_addr_t        s2_waddr,
   output logic [DW-1:0]    s2_data,
   output logic             s2_late,
   output logic             s3_we,
   output reg_addr_t        s3_waddr,
   output logic [DW-1:0]    s3_data,
   output logic             res_valid,
   input  wire              res_ready,
   output reg_addr_t        res_rd,
   output logic [DW-1:0]    res_data
);

   logic          ro_load;
   logic          ro_vld;
   op_e           ro_op;
   reg_addr_t     ro_rd;
   imm_t          ro_imm;
   logic [DW-1:0] alu_res;
   logic          s1_vld;
   op_e           s1_op;
   reg_addr_t     s1_rd;
   logic [DW-1:0] s1_res;
   logic [DW-1:0] s1_b;
   logic          s2_vld;
   op_e           s2_op;
   reg_addr_t     s2_rd;
   logic [DW-1:0] s2_res;
   logic [DW-1:0] s2_b;
   logic [DW-1:0] mul_lo;
   logic          s3_vld;
   reg_addr_t     s3_rd;
   logic [DW-1:0] s3_res;

   // The whole pipeline moves together unless s3 holds an unaccepted result.
   assign advance = !s3_vld || res_ready;
   assign ro_load = re;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ro_vld <= 1'b0;
         s1_vld <= 1'b0;
         s2_vld <= 1'b0;
         s3_vld <= 1'b0;
      end
      else
      begin
         if (ro_load)
         begin
            ro_vld <= 1'b1;
         end
         else if (advance)
         begin
            ro_vld <= 1'b0;
         end
         if (advance)
         begin
            s1_vld <= ro_vld;
            s2_vld <= s1_vld;
            s3_vld <= s2_vld;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ro_load)
      begin
         ro_op  <= iss_op;
         ro_rd  <= iss_rd;
         ro_imm <= iss_imm;
      end
   end

   // Single-cycle ops finish on the way into s1. A multiply carries its
   // two operands along in s1_res and s1_b.
   always_comb
   begin
      case (ro_op)
         OP_ADD:  alu_res = opnd1 + opnd2;
         OP_SUB:  alu_res = opnd1 - opnd2;
         OP_XOR:  alu_res = opnd1 ^ opnd2;
         OP_LI:   alu_res = DW'(ro_imm);
         OP_MUL:  alu_res = opnd1;
         default: alu_res = '0;
      endcase
   end

   assign mul_lo = s2_res * s2_b;

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         s1_op  <= ro_op;
         s1_rd  <= ro_rd;
         s1_res <= alu_res;
         s1_b   <= opnd2;
         s2_op  <= s1_op;
         s2_rd  <= s1_rd;
         s2_res <= s1_res;
         s2_b   <= s1_b;
         s3_rd  <= s2_rd;
         s3_res <= s3_data;
      end
   end

   // Each sN port describes the write that the next advance places in sN.
   assign s1_we    = ro_vld && (ro_rd != '0);
   assign s1_waddr = ro_rd;
   assign s1_data  = alu_res;
   assign s1_late  = ro_vld && (ro_op == OP_MUL);

   assign s2_we    = s1_vld && (s1_rd != '0);
   assign s2_waddr = s1_rd;
   assign s2_data  = s1_res;
   assign s2_late  = s1_vld && (s1_op == OP_MUL);

   // The s3 write commits to the register file at this edge, so it needs advance.
   assign s3_we    = advance && s2_vld && (s2_rd != '0);
   assign s3_waddr = s2_rd;
   assign s3_data  = (s2_op == OP_MUL) ? mul_lo : s2_res;

   assign res_valid = s3_vld;
   assign res_rd    = s3_rd;
   assign res_data  = s3_res;

   a_res_hold: assert property (@(posedge clk) disable iff (rst)
      (res_valid && !res_ready) |=> (res_valid && $stable(res_rd) && $stable(res_data)));

endmodule

`default_nettype wire

// File: design/core_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top: issue, register file, bypass and execute.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*;
#(
   parameter int DW = 16
)
(
   input  wire              clk,
   input  wire              rst,
   input  wire              in_valid,
   output logic             in_ready,
   input  wire instr_t      in_instr,
   output logic             res_valid,
   input  wire              res_ready,
   output reg_addr_t        res_rd,
   output logic [DW-1:0]    res_data
);

   reg_addr_t     raddr1;
   reg_addr_t     raddr2;
   logic          re;
   logic [2*DW-1:0] rf_din;
   logic          raw_dep_late;
   logic          advance;
   op_e           iss_op;
   reg_addr_t     iss_rd;
   imm_t          iss_imm;
   logic [DW-1:0] opnd1;
   logic [DW-1:0] opnd2;
   logic          s1_we;
   reg_addr_t     s1_waddr;
   logic [DW-1:0] s1_data;
   logic          s1_late;
   logic          s2_we;
   reg_addr_t     s2_waddr;
   logic [DW-1:0] s2_data;
   logic          s2_late;
   logic          s3_we;
   reg_addr_t     s3_waddr;
   logic [DW-1:0] s3_data;

   op_issue i_issue
   (
      .clk(clk), .rst(rst),
      .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
      .advance(advance), .raw_dep_late(raw_dep_late),
      .raddr1(raddr1), .raddr2(raddr2), .re(re),
      .iss_op(iss_op), .iss_rd(iss_rd), .iss_imm(iss_imm)
   );

   // The s3 write doubles as the register file write port.
   reg_file #(.DW(DW)) i_rf
   (
      .clk(clk), .rst(rst),
      .raddr1(raddr1), .raddr2(raddr2), .re(re), .rf_din(rf_din),
      .we(s3_we), .waddr(s3_waddr), .wdata(s3_data)
   );

   operand_bypass #(.DW(DW)) i_byp
   (
      .clk(clk),
      .raddr1(raddr1), .raddr2(raddr2), .re(re),
      .s1_we(s1_we), .s1_waddr(s1_waddr), .s1_data(s1_data), .s1_late(s1_late),
      .s2_we(s2_we), .s2_waddr(s2_waddr), .s2_data(s2_data), .s2_late(s2_late),
      .s3_we(s3_we), .s3_waddr(s3_waddr), .s3_data(s3_data),
      .rf_din(rf_din),
      .opnd1(opnd1), .opnd2(opnd2), .raw_dep_late(raw_dep_late)
   );

   exec_pipe #(.DW(DW)) i_exec
   (
      .clk(clk), .rst(rst),
      .re(re), .iss_op(iss_op), .iss_rd(iss_rd), .iss_imm(iss_imm),
      .opnd1(opnd1), .opnd2(opnd2), .advance(advance),
      .s1_we(s1_we), .s1_waddr(s1_waddr), .s1_data(s1_data), .s1_late(s1_late),
      .s2_we(s2_we), .s2_waddr(s2_waddr), .s2_data(s2_data), .s2_late(s2_late),
      .s3_we(s3_we), .s3_waddr(s3_waddr), .s3_data(s3_data),
      .res_valid(res_valid), .res_ready(res_ready),
      .res_rd(res_rd), .res_data(res_data)
   );

endmodule

`default_nettype wire

// File: tb/tb_prog_table.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test programs and result back-pressure patterns for the core.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_PROG_TABLE_SVH
`define TB_PROG_TABLE_SVH

localparam int NUM_TESTS  = 7;
localparam int PROG_WORDS = 65;

// One row per test. A test with ready_rand set takes res_ready from the random source,
// otherwise res_ready follows ready_pat one bit per cycle.
string       test_name  [NUM_TESTS] = '{"reset_reads", "alu_basic", "forwarding",
                                        "reg0_dest", "mul_dep", "mul_nodep", "backpressure"};
int          prog_count [NUM_TESTS] = '{8, 11, 16, 6, 6, 6, 12};
logic [15:0] ready_pat  [NUM_TESTS] = '{16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hCCCC,
                                        16'hFFFF, 16'hFFFF, 16'hFFFF};
logic        ready_rand [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

// Words are {op, rd, rs1, rs2}, or {OP_LI, rd, imm8}. The rows follow each other in order.
instr_t prog_words [PROG_WORDS] = '{
   // Every register is read once before anything writes it.
   {OP_ADD, 4'd1, 4'd1, 4'd2}, {OP_XOR, 4'd3, 4'd3, 4'd4}, {OP_SUB, 4'd5, 4'd5, 4'd6},
   {OP_ADD, 4'd7, 4'd7, 4'd8}, {OP_XOR, 4'd9, 4'd9, 4'd10}, {OP_SUB, 4'd11, 4'd11, 4'd12},
   {OP_ADD, 4'd13, 4'd13, 4'd14}, {OP_ADD, 4'd0, 4'd15, 4'd0},
   // Operands written long before their use.
   {OP_LI, 4'd1, 8'h35}, {OP_LI, 4'd2, 8'hF0}, {OP_LI, 4'd3, 8'h07}, {OP_LI, 4'd4, 8'hFF},
   {OP_LI, 4'd9, 8'h01}, {OP_LI, 4'd10, 8'h02}, {OP_LI, 4'd11, 8'h03},
   {OP_ADD, 4'd5, 4'd1, 4'd2}, {OP_SUB, 4'd6, 4'd3, 4'd4}, {OP_XOR, 4'd7, 4'd1, 4'd2},
   {OP_ADD, 4'd8, 4'd4, 4'd4},
   // Distances 1 to 4, then two pending writes to r6.
   {OP_LI, 4'd1, 8'h11}, {OP_ADD, 4'd2, 4'd1, 4'd1}, {OP_LI, 4'd3, 8'h40},
   {OP_SUB, 4'd4, 4'd2, 4'd1}, {OP_XOR, 4'd5, 4'd3, 4'd1}, {OP_LI, 4'd6, 8'h01},
   {OP_LI, 4'd6, 8'h02}, {OP_ADD, 4'd7, 4'd6, 4'd6}, {OP_LI, 4'd6, 8'h03},
   {OP_LI, 4'd8, 8'h09}, {OP_LI, 4'd6, 8'h04}, {OP_XOR, 4'd9, 4'd6, 4'd8},
   {OP_LI, 4'd11, 8'h7F}, {OP_LI, 4'd12, 8'h01}, {OP_LI, 4'd13, 8'h02},
   {OP_ADD, 4'd14, 4'd11, 4'd12},
   {OP_LI, 4'd0, 8'h55}, {OP_ADD, 4'd1, 4'd0, 4'd0}, {OP_LI, 4'd2, 8'h10},
   {OP_ADD, 4'd0, 4'd2, 4'd2}, {OP_ADD, 4'd3, 4'd0, 4'd2}, {OP_SUB, 4'd4, 4'd2, 4'd0},
   // The same multiplies, first with and then without an immediate use.
   {OP_LI, 4'd1, 8'hC8}, {OP_LI, 4'd2, 8'hFA}, {OP_MUL, 4'd3, 4'd1, 4'd2},
   {OP_ADD, 4'd4, 4'd3, 4'd3}, {OP_MUL, 4'd5, 4'd3, 4'd3}, {OP_XOR, 4'd6, 4'd5, 4'd1},
   {OP_LI, 4'd1, 8'hC8}, {OP_LI, 4'd2, 8'hFA}, {OP_MUL, 4'd3, 4'd1, 4'd2},
   {OP_ADD, 4'd4, 4'd1, 4'd2}, {OP_MUL, 4'd5, 4'd2, 4'd2}, {OP_XOR, 4'd6, 4'd1, 4'd2},
   {OP_LI, 4'd1, 8'h9C}, {OP_LI, 4'd2, 8'h3B}, {OP_MUL, 4'd3, 4'd1, 4'd2},
   {OP_ADD, 4'd4, 4'd3, 4'd1}, {OP_SUB, 4'd5, 4'd4, 4'd2}, {OP_XOR, 4'd6, 4'd5, 4'd3},
   {OP_MUL, 4'd7, 4'd6, 4'd6}, {OP_ADD, 4'd0, 4'd7, 4'd7}, {OP_LI, 4'd8, 8'hE1},
   {OP_SUB, 4'd9, 4'd0, 4'd8}, {OP_MUL, 4'd10, 4'd9, 4'd7}, {OP_XOR, 4'd11, 4'd10, 4'd10}
};

`endif

// File: tb/tb_core_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the core: program driver, reference model, result checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_core_top
   import core_pkg::*;
();

   localparam int DW         = 16;
   localparam int CLK_HALF   = 10;
   localparam int DRIVE_DLY  = 2;
   localparam int RST_CYCLES = 4;
   localparam int TIMEOUT    = 200;

   logic          clk;
   logic          rst;
   logic          in_valid;
   logic          in_ready;
   instr_t        in_instr;
   logic          res_valid;
   logic          res_ready;
   reg_addr_t     res_rd;
   logic [DW-1:0] res_data;

   `include "tb_prog_table.svh"

   logic [DW-1:0] model_regs [NUM_REGS];
   reg_addr_t     exp_rd_q [$];
   logic [DW-1:0] exp_data_q [$];
   string         cur_test;
   int            errors;
   int            checks;
   logic          timed_out;
   logic [6:0]    word_idx;
   logic [31:0]   rnd_state;
   logic [15:0]   cur_pat;
   logic          cur_rand;
   logic [3:0]    ready_cnt;
   logic          held;
   reg_addr_t     held_rd;
   logic [DW-1:0] held_data;

   core_top #(.DW(DW)) i_dut
   (
      .clk(clk), .rst(rst),
      .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
      .res_valid(res_valid), .res_ready(res_ready),
      .res_rd(res_rd), .res_data(res_data)
   );

   always #CLK_HALF clk = ~clk;

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Executes one accepted instruction and queues the result it must produce.
   task automatic model_accept(input instr_t w);
      op_e           op;
      reg_addr_t     rd;
      logic [DW-1:0] a;
      logic [DW-1:0] b;
      logic [DW-1:0] r;
      op = op_e'(w[14:12]);
      rd = w[11:8];
      a  = model_regs[w[7:4]];
      b  = model_regs[w[3:0]];
      r  = '0;
      case (op)
         OP_ADD:  r = a + b;
         OP_SUB:  r = a - b;
         OP_XOR:  r = a ^ b;
         OP_MUL:  r = a * b;
         OP_LI:   r[7:0] = w[7:0];
         default: r = 'x;
      endcase
      // Register 0 is never written, so it keeps reading zero.
      if (rd != '0)
      begin
         model_regs[rd] = r;
      end
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(r);
   endtask

   // Offers one instruction and returns a drive delay after the edge that took it.
   task automatic send_instr(input instr_t w);
      int   waited;
      logic taken;
      in_valid = 1'b1;
      in_instr = w;
      taken    = 1'b0;
      waited   = 0;
      while (!taken && waited < TIMEOUT)
      begin
         @(negedge clk);
         taken = in_ready;
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
      end
      if (taken)
      begin
         model_accept(w);
      end
      else
      begin
         $display("Timeout in %s: the core did not accept instruction %h", cur_test, w);
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic run_test(input logic [2:0] t);
      int waited;
      cur_test = test_name[t];
      cur_pat  = ready_pat[t];
      cur_rand = ready_rand[t];
      for (int i = 0; i < prog_count[t] && !timed_out; i++)
      begin
         send_instr(prog_words[word_idx]);
         word_idx = word_idx + 7'd1;
      end
      in_valid = 1'b0;
      waited   = 0;
      while (exp_rd_q.size() != 0 && waited < TIMEOUT && !timed_out)
      begin
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
      end
      if (exp_rd_q.size() != 0 && !timed_out)
      begin
         $display("Timeout in %s: %0d results never arrived", cur_test, exp_rd_q.size());
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic check_result();
      reg_addr_t     exp_rd;
      logic [DW-1:0] exp_data;
      if (exp_rd_q.size() == 0)
      begin
         $display("Unexpected result in %s: rd %0d arrived with nothing pending",
                  cur_test, res_rd);
         errors++;
      end
      else
      begin
         exp_rd   = exp_rd_q.pop_front();
         exp_data = exp_data_q.pop_front();
         checks++;
         if (res_rd !== exp_rd)
         begin
            $display("Error: %s res_rd expected %0d actual %0d", cur_test, exp_rd, res_rd);
            errors++;
         end
         if (res_data !== exp_data)
         begin
            $display("Error: %s res_data expected %h actual %h", cur_test, exp_data, res_data);
            errors++;
         end
      end
   endtask

   // res_ready changes with the other inputs, a little after the rising edge.
   always @(posedge clk)
   begin
      #DRIVE_DLY;
      if (cur_rand)
      begin
         rnd_state = next_random(rnd_state);
         res_ready = (rnd_state[2:0] > 3'd2);
      end
      else
      begin
         res_ready = cur_pat[ready_cnt];
      end
      ready_cnt = ready_cnt + 4'd1;
   end

   // Outputs are stable at the falling edge and hold the values the next rising edge sees.
   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (held && !res_valid)
         begin
            $display("In %s a held result was withdrawn before it was accepted", cur_test);
            errors++;
         end
         if (held && res_valid && (res_rd !== held_rd || res_data !== held_data))
         begin
            $display("In %s a held result changed before it was accepted", cur_test);
            errors++;
         end
         if (res_valid && res_ready)
         begin
            check_result();
            held = 1'b0;
         end
         else
         begin
            held      = res_valid;
            held_rd   = res_rd;
            held_data = res_data;
         end
      end
   end

   initial
   begin
      logic [2:0] t;
      clk        = 1'b0;
      rst        = 1'b1;
      in_valid   = 1'b0;
      in_instr   = '0;
      res_ready  = 1'b1;
      errors     = 0;
      checks     = 0;
      timed_out  = 1'b0;
      word_idx   = '0;
      rnd_state  = 32'd48;
      cur_pat    = 16'hFFFF;
      cur_rand   = 1'b0;
      ready_cnt  = '0;
      held       = 1'b0;
      cur_test   = "reset";
      model_regs = '{default: '0};
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;

      @(negedge clk);
      if (res_valid !== 1'b0)
      begin
         $display("res_valid is not low after reset");
         errors++;
      end
      if (in_ready !== 1'b1)
      begin
         $display("in_ready is not high after reset");
         errors++;
      end
      @(posedge clk);
      #DRIVE_DLY;

      for (t = 3'd0; t < 3'(NUM_TESTS); t = t + 3'd1)
      begin
         if (!timed_out)
         begin
            run_test(t);
         end
      end

      // A few idle cycles let a stray extra result show up.
      repeat (10) @(posedge clk);
      $display("Summary: %0d results checked, %0d errors", checks, errors);
      if (errors == 0 && !timed_out)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tb
design/core_pkg.sv
design/op_issue.sv
design/reg_file.sv
design/operand_bypass.sv
design/exec_pipe.sv
design/core_top.sv
tb/tb_core_top.sv

// File: Makefile
# Verilator build and run of the core testbench.

VERILATOR ?= verilator
TOP       ?= tb_core_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard design/*.sv tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
